// ==== src.f ====
logic/transmitPkg.sv
logic/averageControl.sv
logic/sampleAccumulator.sv
logic/asyncFifo.sv
logic/dataHandlerForTransmission.sv
testbench/dataHandlerTb.sv

// ==== Makefile ====
TOP = dataHandlerTb

.PHONY: all lint clean

# Build and run; the exit status comes from the search for the pass line
all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -x "SIMULATION PASSED" > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

// ==== testbench/dataHandlerTb.sv ====
`timescale 1ns/1ps

module dataHandlerTb;
    import transmitPkg::*;

    localparam int MODE_RANDOM   = 0;
    localparam int MODE_NEGATIVE = 1;
    localparam int MODE_CONSTANT = 2;
    localparam int READ_TIMEOUT  = 20000;   // Read clock cycles, covers a block of MAX_POINTS
    localparam int FULL_TIMEOUT  = 200;

    typedef struct {
        string name;
        int    length;
        int    blocks;
        int    mode;
        bit    gaps;        // Random idle cycles between samples
        bit    holdReads;   // Fill the FIFO before any read
        int    newLength;   // Length applied in the middle of the first block, 0 for none
    } testRowT;

    logic                  dataClk = 1'b0;
    logic                  fifoReadClk = 1'b0;
    logic                  rst;
    logic [COUNT_BITS-1:0] nOfDataPerTransmission;
    sampleT                in;
    logic                  enableData;
    logic                  readRequest;
    sampleT                dataRead;
    logic                  readEmpty;
    logic                  full;

    testRowT rows[$];
    sampleT  expected[$];
    int      errorCount = 0;
    int      checkCount = 0;
    int      testCount = 0;
    bit      timedOut = 1'b0;

    always #4 dataClk = ~dataClk;
    always #6.5 fifoReadClk = ~fifoReadClk;   // Unrelated to the sample clock

    dataHandlerForTransmission dataHandlerForTransmission_inst (
        .dataClk                (dataClk),
        .fifoReadClk            (fifoReadClk),
        .rst                    (rst),
        .nOfDataPerTransmission (nOfDataPerTransmission),
        .in                     (in),
        .enableData             (enableData),
        .readRequest            (readRequest),
        .dataRead               (dataRead),
        .readEmpty              (readEmpty),
        .full                   (full)
    );

    task automatic checkValue(input string testName, input logic signed [31:0] expectedValue,
                              input logic signed [31:0] actualValue);
        checkCount++;
        if (actualValue !== expectedValue) begin
            errorCount++;
            $display("CHECK FAILED %s expected %0d actual %0d", testName, expectedValue,
                     actualValue);
        end
    endtask

    task automatic addRow(input string name, input int length, input int blocks, input int mode,
                          input bit gaps, input bit holdReads, input int newLength);
        testRowT row;
        row.name      = name;
        row.length    = length;
        row.blocks    = blocks;
        row.mode      = mode;
        row.gaps      = gaps;
        row.holdReads = holdReads;
        row.newLength = newLength;
        rows.push_back(row);
    endtask

    function automatic sampleT makeSample(input int mode);
        sampleT value;
        case (mode)
            MODE_NEGATIVE: value = {1'b1, 15'($urandom)};
            MODE_CONSTANT: value = {1'b1, 15'b0};   // Most negative sample stresses the sum range
            default:       value = sampleT'($urandom);
        endcase
        return value;
    endfunction

    // Divide by a power of two, rounding toward minus infinity
    function automatic sampleT averageOf(input longint sum, input int length);
        int shift;
        shift = 0;
        while ((1 << shift) < length) begin
            shift++;
        end
        return sampleT'(sum >>> shift);
    endfunction

    task automatic sendBlocks(input testRowT row);
        int     blockLen;
        int     taken;
        longint sum;
        sampleT value;
        blockLen = row.length;
        @(posedge dataClk);
        nOfDataPerTransmission <= COUNT_BITS'(blockLen);
        enableData             <= 1'b0;
        for (int b = 0; b < row.blocks; b++) begin
            sum   = 0;
            taken = 0;
            while (taken < blockLen) begin
                @(posedge dataClk);
                if (row.gaps && (($urandom % 3) == 0)) begin
                    enableData <= 1'b0;
                end else begin
                    value = makeSample(row.mode);
                    in         <= value;
                    enableData <= 1'b1;
                    sum += value;
                    taken++;
                    if (row.newLength != 0 && b == 0 && taken == blockLen / 2) begin
                        nOfDataPerTransmission <= COUNT_BITS'(row.newLength);
                    end
                end
            end
            expected.push_back(averageOf(sum, blockLen));
            if (row.newLength != 0) begin
                blockLen = row.newLength;   // The DUT only picks it up at the next block
            end
        end
        @(posedge dataClk);
        enableData <= 1'b0;
    endtask

    task automatic readWords(input string name, input int count);
        int waited;
        for (int w = 0; w < count; w++) begin
            waited = 0;
            @(negedge fifoReadClk);
            while (readEmpty && waited < READ_TIMEOUT) begin
                @(negedge fifoReadClk);
                waited++;
            end
            if (readEmpty) begin
                $display("Timeout in %s, the FIFO stayed empty while word %0d was awaited",
                         name, w);
                errorCount++;
                timedOut = 1'b1;
                return;
            end
            @(posedge fifoReadClk);
            readRequest <= 1'b1;
            @(posedge fifoReadClk);
            readRequest <= 1'b0;
            @(negedge fifoReadClk);
            if (expected.size() == 0) begin
                $display("Error in %s, a word was read but no average was expected", name);
                errorCount++;
            end else begin
                checkValue(name, expected.pop_front(), dataRead);
            end
        end
    endtask

    task automatic waitForFull(input string name);
        int waited;
        waited = 0;
        @(negedge dataClk);
        while (!full && waited < FULL_TIMEOUT) begin
            @(negedge dataClk);
            waited++;
        end
        if (!full) begin
            $display("Timeout in %s, full never rose after the FIFO was filled", name);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    // Watches a quiet FIFO, nothing may appear in it
    task automatic expectEmptyHeld(input string name, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge fifoReadClk);
            checkValue(name, 1, readEmpty);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("Test %-20s %s, %0d errors", name,
                 (errorCount == errorsBefore) ? "ok" : "bad", errorCount - errorsBefore);
    endtask

    task automatic testAfterReset();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge fifoReadClk);
        checkValue("after reset", 1, readEmpty);
        checkValue("after reset", 0, full);
        @(posedge fifoReadClk);
        readRequest <= 1'b1;   // Must be ignored while empty
        @(posedge fifoReadClk);
        readRequest <= 1'b0;
        expectEmptyHeld("after reset", 4);
        reportTest("after reset", errorsBefore);
    endtask

    task automatic runRow(input testRowT row);
        int errorsBefore;
        errorsBefore = errorCount;
        if (row.holdReads) begin
            sendBlocks(row);
            waitForFull(row.name);
            if (!timedOut) begin
                readWords(row.name, FIFO_DEPTH);
                expectEmptyHeld(row.name, 8);
            end
            expected.delete();   // Averages written while full were dropped
        end else begin
            fork
                sendBlocks(row);
                readWords(row.name, row.blocks);
            join
        end
        reportTest(row.name, errorsBefore);
    endtask

    initial begin
        rst                    = 1'b1;
        enableData             = 1'b0;
        in                     = '0;
        nOfDataPerTransmission = COUNT_BITS'(1);
        readRequest            = 1'b0;
        void'($urandom(32'hbafd));

        addRow("average len 1",     1,    12, MODE_RANDOM,   0, 0, 0);
        addRow("average len 4",     4,    12, MODE_RANDOM,   0, 0, 0);
        addRow("average len 16",    16,   6,  MODE_RANDOM,   0, 0, 0);
        addRow("average len 4096",  4096, 2,  MODE_RANDOM,   0, 0, 0);
        addRow("negative rounding", 8,    8,  MODE_NEGATIVE, 0, 0, 0);
        addRow("extreme constant",  4096, 1,  MODE_CONSTANT, 0, 0, 0);
        addRow("enable gaps",       16,   6,  MODE_RANDOM,   1, 0, 0);
        addRow("full and overflow", 4, FIFO_DEPTH + 3, MODE_RANDOM, 0, 1, 0);
        addRow("length latched",    8,    3,  MODE_RANDOM,   0, 0, 2);

        repeat (4) @(posedge fifoReadClk);
        rst <= 1'b0;

        testAfterReset();
        foreach (rows[i]) begin
            if (!timedOut) begin
                runRow(rows[i]);
            end
        end

        $display("Tests run %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/dataHandlerForTransmission.sv ====
`timescale 1ns/1ps

module dataHandlerForTransmission (
    input  logic                               dataClk,
    input  logic                               fifoReadClk,
    input  logic                               rst,
    input  logic [transmitPkg::COUNT_BITS-1:0] nOfDataPerTransmission,
    input  transmitPkg::sampleT                in,
    input  logic                               enableData,
    input  logic                               readRequest,
    output transmitPkg::sampleT                dataRead,
    output logic                               readEmpty,
    output logic                               full
);
    import transmitPkg::*;

    avgCtrlT               ctrl;
    logic [SHIFT_BITS-1:0] shiftAmount;
    sampleT                avgData;
    logic                  avgWrite;

    averageControl averageControl_inst (
        .dataClk                (dataClk),
        .rst                    (rst),
        .enableData             (enableData),
        .nOfDataPerTransmission (nOfDataPerTransmission),
        .ctrl                   (ctrl),
        .shiftAmount            (shiftAmount)
    );

    sampleAccumulator sampleAccumulator_inst (
        .dataClk     (dataClk),
        .rst         (rst),
        .ctrl        (ctrl),
        .shiftAmount (shiftAmount),
        .sample      (in),
        .avgData     (avgData),
        .avgWrite    (avgWrite)
    );

    // Averages cross from the sample clock to the consumer clock here
    asyncFifo asyncFifo_inst (
        .wrClk     (dataClk),
        .rdClk     (fifoReadClk),
        .rst       (rst),
        .wrData    (avgData),
        .wrEnable  (avgWrite),
        .rdRequest (readRequest),
        .rdData    (dataRead),
        .rdEmpty   (readEmpty),
        .wrFull    (full)
    );

endmodule

// ==== logic/asyncFifo.sv ====
`timescale 1ns/1ps

module asyncFifo (
    input  logic                wrClk,
    input  logic                rdClk,
    input  logic                rst,
    input  transmitPkg::sampleT wrData,
    input  logic                wrEnable,
    input  logic                rdRequest,
    output transmitPkg::sampleT rdData,
    output logic                rdEmpty,
    output logic                wrFull
);
    import transmitPkg::*;

    sampleT mem [FIFO_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [FIFO_ADDR_BITS:0] wrBin;
    logic [FIFO_ADDR_BITS:0] wrBinNext;
    logic [FIFO_ADDR_BITS:0] wrGray;
    logic [FIFO_ADDR_BITS:0] wrGrayNext;
    logic [FIFO_ADDR_BITS:0] rdGraySync1;
    logic [FIFO_ADDR_BITS:0] rdGraySync2;
    logic [FIFO_ADDR_BITS:0] rdGrayWrapped;
    logic                    wrPush;

    logic [FIFO_ADDR_BITS:0] rdBin;
    logic [FIFO_ADDR_BITS:0] rdBinNext;
    logic [FIFO_ADDR_BITS:0] rdGray;
    logic [FIFO_ADDR_BITS:0] rdGrayNext;
    logic [FIFO_ADDR_BITS:0] wrGraySync1;
    logic [FIFO_ADDR_BITS:0] wrGraySync2;
    logic                    rdPop;

    function automatic logic [FIFO_ADDR_BITS:0] binToGray(input logic [FIFO_ADDR_BITS:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign wrPush     = wrEnable && !wrFull;    // Writes while full are dropped
    assign wrBinNext  = wrBin + {{FIFO_ADDR_BITS{1'b0}}, wrPush};
    assign wrGrayNext = binToGray(wrBinNext);

    // Full when the write pointer is one lap ahead of the read pointer
    assign rdGrayWrapped = {~rdGraySync2[FIFO_ADDR_BITS:FIFO_ADDR_BITS-1],
                            rdGraySync2[FIFO_ADDR_BITS-2:0]};

    always_ff @(posedge wrClk) begin
        if (rst) begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
            wrFull      <= 1'b0;
        end else begin
            wrBin       <= wrBinNext;
            wrGray      <= wrGrayNext;
            rdGraySync1 <= rdGray;               // Two flops into the write domain
            rdGraySync2 <= rdGraySync1;
            wrFull      <= (wrGrayNext == rdGrayWrapped);
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrPush) begin
            mem[wrBin[FIFO_ADDR_BITS-1:0]] <= wrData;
        end
    end

    assign rdPop      = rdRequest && !rdEmpty;  // Requests while empty are ignored
    assign rdBinNext  = rdBin + {{FIFO_ADDR_BITS{1'b0}}, rdPop};
    assign rdGrayNext = binToGray(rdBinNext);

    always_ff @(posedge rdClk) begin
        if (rst) begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            rdEmpty     <= 1'b1;
        end else begin
            rdBin       <= rdBinNext;
            rdGray      <= rdGrayNext;
            wrGraySync1 <= wrGray;               // Two flops into the read domain
            wrGraySync2 <= wrGraySync1;
            rdEmpty     <= (rdGrayNext == wrGraySync2);
        end
    end

    // Non-showahead, the word shows up after the edge that pops it
    always_ff @(posedge rdClk) begin
        if (rdPop) begin
            rdData <= mem[rdBin[FIFO_ADDR_BITS-1:0]];
        end
    end

endmodule

// ==== logic/sampleAccumulator.sv ====
`timescale 1ns/1ps

module sampleAccumulator (
    input  logic                               dataClk,
    input  logic                               rst,
    input  transmitPkg::avgCtrlT               ctrl,
    input  logic [transmitPkg::SHIFT_BITS-1:0] shiftAmount,
    input  transmitPkg::sampleT                sample,
    output transmitPkg::sampleT                avgData,
    output logic                               avgWrite
);
    import transmitPkg::*;

    logic signed [ACC_BITS-1:0] accSum;      // Running sum of the open block
    logic signed [ACC_BITS-1:0] sampleExt;
    logic signed [ACC_BITS-1:0] nextSum;
    logic signed [ACC_BITS-1:0] scaledSum;

    assign sampleExt = sample;               // Sign extends since sample is signed

    // The first sample of a block restarts the sum
    assign nextSum = ctrl.first ? sampleExt : accSum + sampleExt;

    // Arithmetic shift rounds toward minus infinity
    assign scaledSum = nextSum >>> shiftAmount;

    always_ff @(posedge dataClk) begin
        if (ctrl.accept) begin
            accSum <= nextSum;
        end
    end

    // Holds the finished average while the next block already accumulates
    always_ff @(posedge dataClk) begin
        if (ctrl.accept && ctrl.last) begin
            avgData <= scaledSum[DATA_BITS-1:0];
        end
    end

    always_ff @(posedge dataClk) begin
        if (rst) begin
            avgWrite <= 1'b0;
        end else begin
            avgWrite <= ctrl.accept && ctrl.last;   // One cycle pulse per block
        end
    end

endmodule

// ==== logic/averageControl.sv ====
`timescale 1ns/1ps

module averageControl (
    input  logic                               dataClk,
    input  logic                               rst,
    input  logic                               enableData,
    input  logic [transmitPkg::COUNT_BITS-1:0] nOfDataPerTransmission,
    output transmitPkg::avgCtrlT               ctrl,
    output logic [transmitPkg::SHIFT_BITS-1:0] shiftAmount
);
    import transmitPkg::*;

    logic [COUNT_BITS-1:0] blockLength;    // Length latched at the first sample of a block
    logic [COUNT_BITS-1:0] remaining;      // Samples still owed to the open block
    logic [COUNT_BITS-1:0] activeLength;
    logic                  blockOpen;

    // Priority encoder, the highest set bit gives the shift
    function automatic logic [SHIFT_BITS-1:0] floorLog2(input logic [COUNT_BITS-1:0] value);
        logic [SHIFT_BITS-1:0] msb;
        msb = '0;
        for (int i = 0; i < COUNT_BITS; i++) begin
            if (value[i]) begin
                msb = SHIFT_BITS'(i);
            end
        end
        return msb;
    endfunction

    assign blockOpen = (remaining != '0);

    // Before the block opens the live input is the length that will be latched
    assign activeLength = blockOpen ? blockLength : nOfDataPerTransmission;

    always_comb begin
        ctrl.accept = enableData;
        ctrl.first  = enableData && !blockOpen;
        if (blockOpen) begin
            ctrl.last = enableData && (remaining == COUNT_BITS'(1));
        end else begin
            ctrl.last = enableData && (nOfDataPerTransmission <= COUNT_BITS'(1));
        end
        shiftAmount = floorLog2(activeLength);
    end

    always_ff @(posedge dataClk) begin
        if (rst) begin
            blockLength <= '0;
            remaining   <= '0;
        end else if (enableData) begin
            if (!blockOpen) begin
                blockLength <= nOfDataPerTransmission;
                // A zero length is handled like a block of one
                if (nOfDataPerTransmission == '0) begin
                    remaining <= '0;
                end else begin
                    remaining <= nOfDataPerTransmission - COUNT_BITS'(1);
                end
            end else begin
                remaining <= remaining - COUNT_BITS'(1);
            end
        end
    end

endmodule

// ==== logic/transmitPkg.sv ====
package transmitPkg;

    // Sample and average width
    localparam int DATA_BITS = 16;

    // Longest block of samples that can be averaged
    localparam int MAX_POINTS = 4096;

    // Wide enough to hold MAX_POINTS itself
    localparam int COUNT_BITS = $clog2(MAX_POINTS + 1);

    // Largest shift is log2(MAX_POINTS)
    localparam int SHIFT_BITS = $clog2(COUNT_BITS);

    // A full block of extreme samples cannot overflow this
    localparam int ACC_BITS = COUNT_BITS + DATA_BITS;

    localparam int FIFO_DEPTH     = 16;                   // Must stay a power of two
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    typedef logic signed [DATA_BITS-1:0] sampleT;

    // Per-sample control from the block counter to the accumulator
    typedef struct packed {
        logic accept;   // A sample is taken this cycle
        logic first;    // This sample opens a block
        logic last;     // This sample closes a block
    } avgCtrlT;

endpackage
